/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mni
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Regression passed

SOURCES := $(wildcard hdl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, not the exit status of the simulation
run: $(SIM_EXE)
	-$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "PASS: $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/flit_link_if.sv */
`timescale 1ns/10ps

// One flit stream, moves when valid and ready are both high
interface flit_link_if;
	import mni_pkg::*;

	logic valid;
	flit_kind_e kind;
	flit_payload_u payload;
	logic last;
	logic ready;

	modport sender (
		output valid,
		output kind,
		output payload,
		output last,
		input ready
	);

	modport receiver (
		input valid,
		input kind,
		input payload,
		input last,
		output ready
	);

endinterface

/* hdl/mni_depacketizer.sv */
`timescale 1ns/10ps

module mni_depacketizer (
	input logic clk,
	input logic rst_n,

	flit_link_if.receiver bwd_link,

	input logic [1:0] rsp_dready,
	output logic rsp_valid,
	output logic [mni_pkg::DATA_W-1:0] rsp_rdata,
	output logic [mni_pkg::BURDEN_W-1:0] rsp_burden,
	output logic rsp_done
);
	import mni_pkg::*;

	typedef enum logic [1:0] {
		D_HEAD,
		D_DATA,
		D_HOLD
	} dpk_state_e;

	dpk_state_e state;
	logic take;
	logic hold_write;

	// Link stalls while a response waits on the local master
	assign bwd_link.ready = (state != D_HOLD);
	assign take = bwd_link.valid && bwd_link.ready;

	assign rsp_valid = (state == D_HOLD);
	// Write acknowledge completes on bit 0, read data on bit 1
	assign rsp_done = rsp_valid && (hold_write ? rsp_dready[0] : rsp_dready[1]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= D_HEAD;
		end else begin
			case (state)
				D_HEAD: if (take) state <= D_DATA;
				D_DATA: if (take && bwd_link.last) state <= D_HOLD;
				D_HOLD: if (rsp_done) state <= D_HEAD;
				default: state <= D_HEAD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take && state == D_HEAD) begin
			rsp_burden <= bwd_link.payload.head.burden;
			hold_write <= bwd_link.payload.head.write;
		end
		if (take && state == D_DATA) begin
			rsp_rdata <= bwd_link.payload.data;
		end
	end

	a_response_head: assert property (@(posedge clk) disable iff (!rst_n)
		take && state == D_HEAD |->
			bwd_link.kind == FLIT_HEAD && bwd_link.payload.head.response)
		else $error("backward packet head without response flag");

endmodule

/* hdl/mni_node_top.sv */
`timescale 1ns/10ps

module mni_node_top (
	input logic clk,
	input logic rst_n,
	input logic comm_disable,

	input logic req_valid,
	output logic [1:0] req_dready,
	input logic [mni_pkg::ADDR_W-1:0] req_addr,
	input logic req_write,
	input logic [mni_pkg::DATA_W-1:0] req_wdata,
	input logic [mni_pkg::PERMIT_W-1:0] req_wpermit,
	input logic [mni_pkg::BURDEN_W-1:0] req_burden,

	input logic [1:0] rsp_dready,
	output logic rsp_valid,
	output logic [mni_pkg::DATA_W-1:0] rsp_rdata,
	output logic [mni_pkg::BURDEN_W-1:0] rsp_burden
);

	// Held command between request stage and packetizer
	logic cmd_valid;
	logic [mni_pkg::ADDR_W-1:0] cmd_addr;
	logic cmd_write;
	logic [mni_pkg::DATA_W-1:0] cmd_wdata;
	logic [mni_pkg::PERMIT_W-1:0] cmd_permit;
	logic [mni_pkg::BURDEN_W-1:0] cmd_burden;
	logic cmd_taken;
	logic rsp_done;

	flit_link_if fwd_link ();
	flit_link_if bwd_link ();

	// ********************************************************************
	// Master side, request path
	// ********************************************************************
	mni_request_stage u_request_stage (
		.clk(clk),
		.rst_n(rst_n),
		.comm_disable(comm_disable),
		.req_valid(req_valid),
		.req_dready(req_dready),
		.req_addr(req_addr),
		.req_write(req_write),
		.req_wdata(req_wdata),
		.req_wpermit(req_wpermit),
		.req_burden(req_burden),
		.cmd_valid(cmd_valid),
		.cmd_addr(cmd_addr),
		.cmd_write(cmd_write),
		.cmd_wdata(cmd_wdata),
		.cmd_permit(cmd_permit),
		.cmd_burden(cmd_burden),
		.cmd_taken(cmd_taken),
		.rsp_done(rsp_done)
	);

	mni_packetizer u_packetizer (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_addr(cmd_addr),
		.cmd_write(cmd_write),
		.cmd_wdata(cmd_wdata),
		.cmd_permit(cmd_permit),
		.cmd_burden(cmd_burden),
		.cmd_taken(cmd_taken),
		.fwd_link(fwd_link.sender)
	);

	// Slave side closes the loop
	sni_memory_target u_target (
		.clk(clk),
		.rst_n(rst_n),
		.fwd_link(fwd_link.receiver),
		.bwd_link(bwd_link.sender)
	);

	mni_depacketizer u_depacketizer (
		.clk(clk),
		.rst_n(rst_n),
		.bwd_link(bwd_link.receiver),
		.rsp_dready(rsp_dready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.rsp_burden(rsp_burden),
		.rsp_done(rsp_done)
	);

endmodule

/* hdl/mni_packetizer.sv */
`timescale 1ns/10ps

module mni_packetizer (
	input logic clk,
	input logic rst_n,

	input logic cmd_valid,
	input logic [mni_pkg::ADDR_W-1:0] cmd_addr,
	input logic cmd_write,
	input logic [mni_pkg::DATA_W-1:0] cmd_wdata,
	input logic [mni_pkg::PERMIT_W-1:0] cmd_permit,
	input logic [mni_pkg::BURDEN_W-1:0] cmd_burden,
	output logic cmd_taken,

	flit_link_if.sender fwd_link
);
	import mni_pkg::*;

	typedef enum logic [1:0] {
		P_IDLE,
		P_HEAD,
		P_ADDR,
		P_DATA
	} pkt_state_e;

	pkt_state_e state;
	flit_t tx_flit;
	logic tx_valid;
	logic tx_last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= P_IDLE;
		end else begin
			case (state)
				P_IDLE: if (cmd_valid) state <= P_HEAD;
				P_HEAD: if (fwd_link.ready) state <= P_ADDR;
				P_ADDR: if (fwd_link.ready) state <= cmd_write ? P_DATA : P_IDLE;
				P_DATA: if (fwd_link.ready) state <= P_IDLE;
				default: state <= P_IDLE;
			endcase
		end
	end

	// ********************************************************************
	// Flit build, straight from the held command
	// ********************************************************************
	always_comb begin
		tx_flit = '0;
		case (state)
			P_HEAD: begin
				tx_flit.kind = FLIT_HEAD;
				tx_flit.payload.head.burden = cmd_burden;
				tx_flit.payload.head.write = cmd_write;
				tx_flit.payload.head.response = 1'b0;
				tx_flit.payload.head.permit = cmd_permit;
			end
			P_ADDR: begin
				// a read ends on its address flit
				tx_flit.kind = cmd_write ? FLIT_BODY : FLIT_TAIL;
				tx_flit.payload.data = cmd_addr;
			end
			P_DATA: begin
				tx_flit.kind = FLIT_TAIL;
				tx_flit.payload.data = cmd_wdata;
			end
			default: ;
		endcase
	end

	assign tx_valid = (state != P_IDLE);
	assign tx_last = (tx_flit.kind == FLIT_TAIL);

	assign fwd_link.valid = tx_valid;
	assign fwd_link.kind = tx_flit.kind;
	assign fwd_link.payload = tx_flit.payload;
	assign fwd_link.last = tx_last;

	// Command leaves with its tail flit
	assign cmd_taken = tx_valid && fwd_link.ready && tx_last;

	a_hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !fwd_link.ready |=> tx_valid && $stable(tx_flit))
		else $error("forward flit changed while stalled");

endmodule

/* hdl/mni_pkg.sv */
package mni_pkg;

	// ********************************************************************
	// Node widths
	// ********************************************************************
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int PERMIT_W = 4;
	localparam int BURDEN_W = 4;

	// Target memory and credit sizing
	localparam int MEM_WORDS = 16;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int MAX_OUTSTANDING = 2;
	localparam int OUT_CNT_W = $clog2(MAX_OUTSTANDING + 1);

	// ********************************************************************
	// Flit format
	// ********************************************************************
	typedef enum logic [1:0] {
		FLIT_HEAD = 2'd0,
		FLIT_BODY = 2'd1,
		FLIT_TAIL = 2'd2
	} flit_kind_e;

	// Head word, burden sits in the top bits
	typedef struct packed {
		logic [BURDEN_W-1:0] burden;
		logic write;
		logic response;
		logic [PERMIT_W-1:0] permit;
		logic [DATA_W-BURDEN_W-PERMIT_W-3:0] pad;
	} flit_head_t;

	// Head flits decode through head, body and tail flits through data
	typedef union packed {
		flit_head_t head;
		logic [DATA_W-1:0] data;
	} flit_payload_u;

	typedef struct packed {
		flit_kind_e kind;
		flit_payload_u payload;
	} flit_t;

endpackage

/* hdl/mni_request_stage.sv */
`timescale 1ns/10ps

module mni_request_stage (
	input logic clk,
	input logic rst_n,
	input logic comm_disable,

	input logic req_valid,
	output logic [1:0] req_dready,
	input logic [mni_pkg::ADDR_W-1:0] req_addr,
	input logic req_write,
	input logic [mni_pkg::DATA_W-1:0] req_wdata,
	input logic [mni_pkg::PERMIT_W-1:0] req_wpermit,
	input logic [mni_pkg::BURDEN_W-1:0] req_burden,

	output logic cmd_valid,
	output logic [mni_pkg::ADDR_W-1:0] cmd_addr,
	output logic cmd_write,
	output logic [mni_pkg::DATA_W-1:0] cmd_wdata,
	output logic [mni_pkg::PERMIT_W-1:0] cmd_permit,
	output logic [mni_pkg::BURDEN_W-1:0] cmd_burden,
	input logic cmd_taken,

	input logic rsp_done
);
	import mni_pkg::*;

	logic alive;
	logic [OUT_CNT_W-1:0] out_cnt;
	logic credits_full;
	logic cmd_busy;
	logic req_accept;

	// Held low through reset and its last cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alive <= 1'b0;
		end else begin
			alive <= 1'b1;
		end
	end

	assign credits_full = (out_cnt == OUT_CNT_W'(MAX_OUTSTANDING));
	assign cmd_busy = cmd_valid && !cmd_taken;
	assign req_dready = (!alive || comm_disable || cmd_busy || credits_full) ? 2'b00 : 2'b11;

	// bit 0 takes writes, bit 1 takes reads
	assign req_accept = req_valid && (req_write ? req_dready[0] : req_dready[1]);

	// ********************************************************************
	// Command register
	// ********************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_valid <= 1'b0;
		end else if (req_accept) begin
			cmd_valid <= 1'b1;
		end else if (cmd_taken) begin
			cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_accept) begin
			cmd_addr <= req_addr;
			cmd_write <= req_write;
			cmd_wdata <= req_wdata;
			cmd_permit <= req_wpermit;
			cmd_burden <= req_burden;
		end
	end

	// Requests in flight, from acceptance until the response completes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_cnt <= '0;
		end else if (req_accept && !rsp_done) begin
			out_cnt <= out_cnt + 1'b1;
		end else if (rsp_done && !req_accept) begin
			out_cnt <= out_cnt - 1'b1;
		end
	end

	a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
		(out_cnt <= OUT_CNT_W'(MAX_OUTSTANDING)) && !(rsp_done && out_cnt == '0))
		else $error("outstanding counter out of range");

endmodule

/* hdl/sni_memory_target.sv */
`timescale 1ns/10ps

module sni_memory_target (
	input logic clk,
	input logic rst_n,

	flit_link_if.receiver fwd_link,
	flit_link_if.sender bwd_link
);
	import mni_pkg::*;

	typedef enum logic [2:0] {
		T_HEAD,
		T_ADDR,
		T_DATA,
		T_RSP_HEAD,
		T_RSP_TAIL
	} tgt_state_e;

	tgt_state_e state;
	logic take;
	logic [MEM_IDX_W-1:0] rd_idx;
	logic [DATA_W-1:0] mem [MEM_WORDS];

	// Request fields and response word
	logic [BURDEN_W-1:0] req_burden;
	logic req_write;
	logic [PERMIT_W-1:0] req_permit;
	logic [MEM_IDX_W-1:0] word_idx;
	logic [DATA_W-1:0] rsp_data;
	flit_t rsp_flit;

	// No request flits while a response is on its way out
	assign fwd_link.ready = (state == T_HEAD) || (state == T_ADDR) || (state == T_DATA);
	assign take = fwd_link.valid && fwd_link.ready;

	// Only address bits 5..2 matter
	assign rd_idx = fwd_link.payload.data[MEM_IDX_W+1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= T_HEAD;
		end else begin
			case (state)
				T_HEAD: if (take) state <= T_ADDR;
				T_ADDR: if (take) state <= fwd_link.last ? T_RSP_HEAD : T_DATA;
				T_DATA: if (take) state <= T_RSP_HEAD;
				T_RSP_HEAD: if (bwd_link.ready) state <= T_RSP_TAIL;
				T_RSP_TAIL: if (bwd_link.ready) state <= T_HEAD;
				default: state <= T_HEAD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take && state == T_HEAD) begin
			req_burden <= fwd_link.payload.head.burden;
			req_write <= fwd_link.payload.head.write;
			req_permit <= fwd_link.payload.head.permit;
		end
		if (take && state == T_ADDR) begin
			word_idx <= rd_idx;
			if (fwd_link.last) begin
				rsp_data <= mem[rd_idx];
			end
		end
		// write acknowledge carries a zero word
		if (take && state == T_DATA) begin
			rsp_data <= '0;
		end
	end

	// ********************************************************************
	// Memory, byte merge under the permit bits
	// ********************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (take && state == T_DATA) begin
			for (int b = 0; b < PERMIT_W; b++) begin
				if (req_permit[b]) begin
					mem[word_idx][8*b +: 8] <= fwd_link.payload.data[8*b +: 8];
				end
			end
		end
	end

	// Response packet
	always_comb begin
		rsp_flit = '0;
		if (state == T_RSP_HEAD) begin
			rsp_flit.kind = FLIT_HEAD;
			rsp_flit.payload.head.burden = req_burden;
			rsp_flit.payload.head.write = req_write;
			rsp_flit.payload.head.response = 1'b1;
			rsp_flit.payload.head.permit = req_permit;
		end else begin
			rsp_flit.kind = FLIT_TAIL;
			rsp_flit.payload.data = rsp_data;
		end
	end

	assign bwd_link.valid = (state == T_RSP_HEAD) || (state == T_RSP_TAIL);
	assign bwd_link.kind = rsp_flit.kind;
	assign bwd_link.payload = rsp_flit.payload;
	assign bwd_link.last = (state == T_RSP_TAIL);

	a_head_first: assert property (@(posedge clk) disable iff (!rst_n)
		take && state == T_HEAD |-> fwd_link.kind == FLIT_HEAD)
		else $error("request packet did not start with a head flit");

endmodule

/* test/tb_mni_util.svh */
`ifndef TB_MNI_UTIL_SVH
`define TB_MNI_UTIL_SVH

// Wrong value with time, signal, expected and actual
`define FAIL_VALUE(sig_name, exp_val, act_val) \
	begin \
		$display("FAIL t=%0t %s expected 0x%0h got 0x%0h", \
			$time, sig_name, exp_val, act_val); \
		stop_run(); \
	end

`define FAIL_TEXT(msg) \
	begin \
		$display("Error at t=%0t: %s", $time, msg); \
		stop_run(); \
	end

// ********************************************************************
// Random bits from a 16-bit Fibonacci LFSR with taps 16 14 13 11
// ********************************************************************
logic [15:0] lfsr_state = 16'd26506;

function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int width);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < width; i++) begin
		value = {value[30:0], lfsr_bit()};
	end
	return value;
endfunction

// ********************************************************************
// Expected responses in request order
// ********************************************************************
typedef struct packed {
	logic write;
	logic [BURDEN_W-1:0] burden;
	logic [DATA_W-1:0] data;
} exp_rsp_t;

exp_rsp_t exp_q[$];
int exp_count = 0;
logic exp_head_write = 1'b0;
logic [BURDEN_W-1:0] exp_head_burden = '0;
logic [DATA_W-1:0] exp_head_data = '0;

// Head copy is what the assertions look at
function automatic void refresh_head();
	exp_count = exp_q.size();
	if (exp_count > 0) begin
		exp_head_write = exp_q[0].write;
		exp_head_burden = exp_q[0].burden;
		exp_head_data = exp_q[0].data;
	end
endfunction

task automatic push_expected(input logic write, input logic [BURDEN_W-1:0] burden,
		input logic [DATA_W-1:0] data);
	exp_rsp_t entry;
	entry.write = write;
	entry.burden = burden;
	entry.data = data;
	exp_q.push_back(entry);
	refresh_head();
endtask

task automatic pop_expected();
	void'(exp_q.pop_front());
	refresh_head();
endtask

`endif

/* test/tb_mni.sv */
`timescale 1ns/10ps

module tb_mni;
	import mni_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int N_FILL = 12;
	localparam int N_MIXED = 40;
	localparam int N_TRANS = 2 * N_FILL + N_MIXED + 3;
	localparam int WATCHDOG_NS = (RESET_CYCLES + 200 * N_TRANS) * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst_n;
	logic comm_disable;
	logic req_valid;
	logic [1:0] req_dready;
	logic [ADDR_W-1:0] req_addr;
	logic req_write;
	logic [DATA_W-1:0] req_wdata;
	logic [PERMIT_W-1:0] req_wpermit;
	logic [BURDEN_W-1:0] req_burden;
	logic [1:0] rsp_dready;
	logic rsp_valid;
	logic [DATA_W-1:0] rsp_rdata;
	logic [BURDEN_W-1:0] rsp_burden;

	// Reference memory and the write addresses that get read back
	logic [DATA_W-1:0] model_mem [MEM_WORDS];
	logic [ADDR_W-1:0] fill_addr [N_FILL];

	// Events seen on the rising edge, handled on the next falling edge
	logic rst_q = 1'b0;
	logic acc_flag = 1'b0;
	logic done_flag = 1'b0;
	logic hold_pending = 1'b0;
	logic [DATA_W-1:0] held_rdata;
	logic [BURDEN_W-1:0] held_burden;
	logic done_now;
	logic accepted_now;
	logic [1:0] bp_mode;
	int n_reads = 0;
	int n_holds = 0;
	int n_credit_full = 0;
	int n_disabled = 0;

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_mni_util.svh"

	mni_node_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.comm_disable(comm_disable),
		.req_valid(req_valid),
		.req_dready(req_dready),
		.req_addr(req_addr),
		.req_write(req_write),
		.req_wdata(req_wdata),
		.req_wpermit(req_wpermit),
		.req_burden(req_burden),
		.rsp_dready(rsp_dready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.rsp_burden(rsp_burden)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Write acknowledge completes on bit 0, read data on bit 1
	assign done_now = rsp_valid && (exp_head_write ? rsp_dready[0] : rsp_dready[1]);

	always @(posedge clk) begin
		rst_q <= rst_n;
		acc_flag <= rst_n && req_valid && (req_write ? req_dready[0] : req_dready[1]);
		done_flag <= rst_n && done_now;
		hold_pending <= rst_n && rsp_valid && !done_now;
		held_rdata <= rsp_rdata;
		held_burden <= rsp_burden;
	end

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
			input logic [DATA_W-1:0] new_word, input logic [PERMIT_W-1:0] permit);
		logic [DATA_W-1:0] result;
		result = old_word;
		for (int b = 0; b < PERMIT_W; b++) begin
			if (permit[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	// Request inputs still hold the accepted values here
	task automatic accept_in_model();
		logic [3:0] idx;
		idx = req_addr[5:2];
		if (req_write) begin
			model_mem[idx] = merge_bytes(model_mem[idx], req_wdata, req_wpermit);
			push_expected(1'b1, req_burden, '0);
		end else begin
			push_expected(1'b0, req_burden, model_mem[idx]);
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		accepted_now = 1'b0;
		if (done_flag) begin
			if (!exp_head_write)
				n_reads++;
			pop_expected();
		end
		if (acc_flag) begin
			accept_in_model();
			accepted_now = 1'b1;
		end
		if (exp_count == MAX_OUTSTANDING)
			n_credit_full++;
		if (hold_pending)
			n_holds++;
		if (comm_disable && req_valid)
			n_disabled++;
		case (bp_mode)
			2'd0: rsp_dready = 2'b11;
			2'd1: rsp_dready = 2'(rand_bits(2));
			default: rsp_dready = 2'b00;
		endcase
	endtask

	task automatic issue_request(input logic write, input logic [ADDR_W-1:0] addr);
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = rand_bits(DATA_W);
		req_wpermit = PERMIT_W'(rand_bits(PERMIT_W));
		req_burden = BURDEN_W'(rand_bits(BURDEN_W));
		do begin
			next_cycle();
		end while (!accepted_now);
		req_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_count != 0)
			next_cycle();
	endtask

	// ********************************************************************
	// Checks
	// ********************************************************************
	a_reset_dready: assert property (@(posedge clk) !(rst_n && rst_q) |-> req_dready == 2'b00)
		else `FAIL_VALUE("req_dready", 2'b00, $sampled(req_dready))
	a_reset_rsp_valid: assert property (@(posedge clk) !(rst_n && rst_q) |-> !rsp_valid)
		else `FAIL_VALUE("rsp_valid", 1'b0, $sampled(rsp_valid))

	a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> exp_count > 0)
		else `FAIL_TEXT("rsp_valid is high with no request outstanding")
	a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
		done_now |-> rsp_rdata == exp_head_data)
		else `FAIL_VALUE("rsp_rdata", $sampled(exp_head_data), $sampled(rsp_rdata))
	a_rsp_burden: assert property (@(posedge clk) disable iff (!rst_n)
		done_now |-> rsp_burden == exp_head_burden)
		else `FAIL_VALUE("rsp_burden", $sampled(exp_head_burden), $sampled(rsp_burden))

	a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
		exp_count <= MAX_OUTSTANDING)
		else `FAIL_TEXT("more requests in flight than the credit limit allows")
	a_credit_dready: assert property (@(posedge clk) disable iff (!rst_n)
		exp_count == MAX_OUTSTANDING |-> req_dready == 2'b00)
		else `FAIL_VALUE("req_dready", 2'b00, $sampled(req_dready))
	a_disable_dready: assert property (@(posedge clk) disable iff (!rst_n)
		comm_disable |-> req_dready == 2'b00)
		else `FAIL_VALUE("req_dready", 2'b00, $sampled(req_dready))

	// Response left waiting must not change
	a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
		hold_pending |-> rsp_valid)
		else `FAIL_VALUE("rsp_valid", 1'b1, $sampled(rsp_valid))
	a_hold_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		hold_pending |-> rsp_rdata == held_rdata)
		else `FAIL_VALUE("rsp_rdata", $sampled(held_rdata), $sampled(rsp_rdata))
	a_hold_burden: assert property (@(posedge clk) disable iff (!rst_n)
		hold_pending |-> rsp_burden == held_burden)
		else `FAIL_VALUE("rsp_burden", $sampled(held_burden), $sampled(rsp_burden))

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		stop_run();
	end

	// ********************************************************************
	// Stimulus
	// ********************************************************************
	initial begin
		string missing;
		rst_n = 1'b0;
		comm_disable = 1'b0;
		req_valid = 1'b0;
		req_addr = '0;
		req_write = 1'b0;
		req_wdata = '0;
		req_wpermit = '0;
		req_burden = '0;
		rsp_dready = 2'b00;
		bp_mode = 2'd0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (RESET_CYCLES) next_cycle();
		rst_n = 1'b1;

		// Writes with random permits, then read the same words back
		bp_mode = 2'd1;
		for (int i = 0; i < N_FILL; i++) begin
			fill_addr[i] = rand_bits(ADDR_W);
			issue_request(1'b1, fill_addr[i]);
		end
		for (int i = 0; i < N_FILL; i++) begin
			// Upper address bits change, the word index does not
			issue_request(1'b0, {26'(rand_bits(26)), fill_addr[i][5:0]});
		end
		wait_drained();

		for (int i = 0; i < N_MIXED; i++)
			issue_request(1'(rand_bits(1)), rand_bits(ADDR_W));
		wait_drained();

		// Fill both credits, then hold a third request behind comm_disable
		bp_mode = 2'd2;
		issue_request(1'b1, rand_bits(ADDR_W));
		issue_request(1'b0, rand_bits(ADDR_W));
		comm_disable = 1'b1;
		req_valid = 1'b1;
		req_write = 1'b0;
		req_addr = rand_bits(ADDR_W);
		repeat (4) next_cycle();
		bp_mode = 2'd1;
		wait_drained();
		comm_disable = 1'b0;
		do begin
			next_cycle();
		end while (!accepted_now);
		req_valid = 1'b0;
		bp_mode = 2'd0;
		wait_drained();
		repeat (2) next_cycle();

		if (n_reads == 0)
			missing = "no read data response was checked";
		else if (n_holds == 0)
			missing = "no response was held under back-pressure";
		else if (n_credit_full == 0)
			missing = "the credit limit was never reached";
		else if (n_disabled == 0)
			missing = "no request was held off by comm_disable";
		else
			missing = "";
		if (missing != "") begin
			$display("Error: %s", missing);
			stop_run();
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+test
hdl/mni_pkg.sv
hdl/flit_link_if.sv
hdl/mni_request_stage.sv
hdl/mni_packetizer.sv
hdl/sni_memory_target.sv
hdl/mni_depacketizer.sv
hdl/mni_node_top.sv
test/tb_mni.sv
